//--- ranging_pkg.sv
`default_nettype none

package ranging_pkg;

    localparam int NUM_CHANNELS  = 4;
    localparam int CLKS_PER_BIT  = 16;
    localparam int PING_PERIOD   = 256;
    localparam int PINGS_PER_RUN = 4;

    localparam int OFFSET_W   = $clog2(PING_PERIOD);
    localparam int SUM_W      = 16;
    localparam int HIT_W      = 4;
    localparam int CHAN_W     = 2;
    localparam int PING_CNT_W = $clog2(PINGS_PER_RUN + 1);  // Counts up to end of run.
    localparam int BIT_CNT_W  = $clog2(CLKS_PER_BIT);

    // Unknown command bytes behave like NOP.
    typedef enum logic [7:0] {
        CMD_NOP   = 8'h00,
        CMD_START = 8'h53
    } cmd_op_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    typedef enum logic {
        COL_IDLE,
        COL_DRAIN
    } col_state_t;

endpackage

`default_nettype wire

//--- serial_cmd_rx.sv
`timescale 1ns/1ps
`default_nettype none

module serial_cmd_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_serial,
    output logic [7:0] cmd_byte,
    output logic       cmd_strobe,
    output logic       cmd_err
);

    import ranging_pkg::*;

    logic                 rx_meta;
    logic                 rx_sync;
    rx_state_t            state;
    logic [BIT_CNT_W-1:0] bit_clk;
    logic [2:0]           bit_idx;
    logic [7:0]           shift;
    logic                 bit_mid;

    // Two-flop synchronizer. Line idles high.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
        end
    end

    assign bit_mid = (bit_clk == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RX_IDLE;
            bit_clk    <= '0;
            bit_idx    <= '0;
            cmd_strobe <= 1'b0;
            cmd_err    <= 1'b0;
        end else begin
            cmd_strobe <= 1'b0;
            cmd_err    <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_clk <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck the line half a bit into the start bit.
                    if (bit_clk == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        bit_clk <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_clk <= bit_clk + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        bit_clk <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_clk <= bit_clk + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_mid) begin
                        cmd_strobe <= rx_sync;
                        cmd_err    <= !rx_sync;  // Low stop bit.
                        state      <= RX_IDLE;
                    end else begin
                        bit_clk <= bit_clk + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_mid) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign cmd_byte = shift;

    a_strobe_err_excl: assert property (@(posedge clk) disable iff (rst)
        !(cmd_strobe && cmd_err));

endmodule

`default_nettype wire

//--- ping_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ping_sequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] cmd_byte,
    input  logic       cmd_strobe,
    output logic       ping_start,
    output logic       run_done,
    output logic       first_ping,
    output logic       busy
);

    import ranging_pkg::*;

    seq_state_t            state;
    logic [OFFSET_W-1:0]   period_cnt;
    logic [PING_CNT_W-1:0] ping_cnt;
    logic                  start_req;
    logic                  window_edge;
    logic                  last_window;

    always_comb begin
        case (cmd_op_t'(cmd_byte))
            CMD_START: start_req = cmd_strobe;
            CMD_NOP:   start_req = 1'b0;
            default:   start_req = 1'b0;  // Treated as NOP.
        endcase
    end

    assign window_edge = (state == SEQ_RUN) && (period_cnt == '0);
    assign last_window = (ping_cnt == PING_CNT_W'(PINGS_PER_RUN));

    assign ping_start = window_edge && !last_window;
    assign run_done   = window_edge && last_window;
    assign first_ping = window_edge && (ping_cnt == '0);
    assign busy       = (state == SEQ_RUN);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SEQ_IDLE;
            period_cnt <= '0;
            ping_cnt   <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    period_cnt <= '0;
                    ping_cnt   <= '0;
                    if (start_req) begin
                        state <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (run_done) begin
                        state <= SEQ_IDLE;  // Starts are ignored until here.
                    end else if (period_cnt == OFFSET_W'(PING_PERIOD - 1)) begin
                        period_cnt <= '0;
                        ping_cnt   <= ping_cnt + 1'b1;
                    end else begin
                        period_cnt <= period_cnt + 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    a_ping_in_run: assert property (@(posedge clk) disable iff (rst)
        ping_start |-> busy);

endmodule

`default_nettype wire

//--- echo_timer.sv
`timescale 1ns/1ps
`default_nettype none

module echo_timer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ping_start,
    input  logic                          first_ping,
    input  logic                          run_done,
    input  logic                          echo,
    output logic [ranging_pkg::SUM_W-1:0] first_sum,
    output logic [ranging_pkg::SUM_W-1:0] last_sum,
    output logic [ranging_pkg::HIT_W-1:0] hit_count
);

    import ranging_pkg::*;

    logic [OFFSET_W-1:0] offset;
    logic [OFFSET_W-1:0] first_off;
    logic [OFFSET_W-1:0] last_off;
    logic                in_window;
    logic                win_hit;
    logic                echo_hit;
    logic                win_close;

    // Echoes on the window edges themselves do not count.
    assign echo_hit  = echo && in_window && !ping_start && !run_done;
    assign win_close = (ping_start && !first_ping) || run_done;

    // Offset reads 1 on the cycle after ping_start.
    always_ff @(posedge clk) begin
        if (rst) begin
            offset    <= '0;
            in_window <= 1'b0;
        end else if (ping_start) begin
            offset    <= OFFSET_W'(1);
            in_window <= 1'b1;
        end else begin
            offset <= offset + 1'b1;
            if (run_done) begin
                in_window <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_hit <= 1'b0;
        end else if (ping_start || run_done) begin
            win_hit <= 1'b0;
        end else if (echo_hit) begin
            win_hit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (echo_hit) begin
            if (!win_hit) begin
                first_off <= offset;  // Only the first echo.
            end
            last_off <= offset;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_count <= '0;
        end else if (first_ping) begin
            hit_count <= '0;
        end else if (win_close && win_hit) begin
            hit_count <= hit_count + 1'b1;
        end
    end

    // Empty windows add nothing.
    always_ff @(posedge clk) begin
        if (first_ping) begin
            first_sum <= '0;
            last_sum  <= '0;
        end else if (win_close && win_hit) begin
            first_sum <= first_sum + SUM_W'(first_off);
            last_sum  <= last_sum + SUM_W'(last_off);
        end
    end

    a_edges_apart: assert property (@(posedge clk) disable iff (rst)
        !(ping_start && run_done));

    a_hits_bounded: assert property (@(posedge clk) disable iff (rst)
        hit_count <= HIT_W'(PINGS_PER_RUN));

endmodule

`default_nettype wire

//--- result_collector.sv
`timescale 1ns/1ps
`default_nettype none

module result_collector (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   run_done,
    input  logic [ranging_pkg::NUM_CHANNELS*ranging_pkg::SUM_W-1:0] first_sums,
    input  logic [ranging_pkg::NUM_CHANNELS*ranging_pkg::SUM_W-1:0] last_sums,
    input  logic [ranging_pkg::NUM_CHANNELS*ranging_pkg::HIT_W-1:0] hit_counts,
    output logic                                                   result_valid,
    output logic [ranging_pkg::CHAN_W-1:0]                         result_channel,
    output logic [ranging_pkg::HIT_W-1:0]                          result_hits,
    output logic [ranging_pkg::SUM_W-1:0]                          result_first_sum,
    output logic [ranging_pkg::SUM_W-1:0]                          result_last_sum
);

    import ranging_pkg::*;

    col_state_t                        state;
    logic                              run_done_q;
    logic [NUM_CHANNELS*SUM_W-1:0]     snap_first;
    logic [NUM_CHANNELS*SUM_W-1:0]     snap_last;
    logic [NUM_CHANNELS*HIT_W-1:0]     snap_hits;
    logic [CHAN_W-1:0]                 next_chan;

    assign next_chan = result_channel + 1'b1;

    // Totals settle one cycle after run_done.
    always_ff @(posedge clk) begin
        if (rst) begin
            run_done_q <= 1'b0;
        end else begin
            run_done_q <= run_done;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= COL_IDLE;
            result_valid   <= 1'b0;
            result_channel <= '0;
        end else begin
            case (state)
                COL_IDLE: begin
                    if (run_done_q) begin
                        state          <= COL_DRAIN;
                        result_valid   <= 1'b1;
                        result_channel <= '0;
                    end
                end
                COL_DRAIN: begin
                    if (result_channel == CHAN_W'(NUM_CHANNELS - 1)) begin
                        state        <= COL_IDLE;
                        result_valid <= 1'b0;
                    end else begin
                        result_channel <= next_chan;
                    end
                end
                default: state <= COL_IDLE;
            endcase
        end
    end

    // Snapshot keeps the drain safe from a new run clearing the timers.
    always_ff @(posedge clk) begin
        if (state == COL_IDLE && run_done_q) begin
            snap_first       <= first_sums;
            snap_last        <= last_sums;
            snap_hits        <= hit_counts;
            result_first_sum <= first_sums[SUM_W-1:0];  // Channel 0 straight through.
            result_last_sum  <= last_sums[SUM_W-1:0];
            result_hits      <= hit_counts[HIT_W-1:0];
        end else if (state == COL_DRAIN) begin
            result_first_sum <= snap_first[next_chan*SUM_W +: SUM_W];
            result_last_sum  <= snap_last[next_chan*SUM_W +: SUM_W];
            result_hits      <= snap_hits[next_chan*HIT_W +: HIT_W];
        end
    end

    a_valid_in_drain: assert property (@(posedge clk) disable iff (rst)
        (state == COL_IDLE) |-> !result_valid);

endmodule

`default_nettype wire

//--- ranging_top.sv
`timescale 1ns/1ps
`default_nettype none

module ranging_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cmd_serial,
    input  logic [ranging_pkg::NUM_CHANNELS-1:0] echo,
    output logic                                 tx_pulse,
    output logic                                 busy,
    output logic                                 cmd_err,
    output logic                                 result_valid,
    output logic [ranging_pkg::CHAN_W-1:0]       result_channel,
    output logic [ranging_pkg::HIT_W-1:0]        result_hits,
    output logic [ranging_pkg::SUM_W-1:0]        result_first_sum,
    output logic [ranging_pkg::SUM_W-1:0]        result_last_sum
);

    import ranging_pkg::*;

    logic [7:0]                    cmd_byte;
    logic                          cmd_strobe;
    logic                          ping_start;
    logic                          first_ping;
    logic                          run_done;
    logic [NUM_CHANNELS*SUM_W-1:0] first_sums;
    logic [NUM_CHANNELS*SUM_W-1:0] last_sums;
    logic [NUM_CHANNELS*HIT_W-1:0] hit_counts;

    assign tx_pulse = ping_start;  // Transmit fires with each ping.

    serial_cmd_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .rx_serial  (cmd_serial),
        .cmd_byte   (cmd_byte),
        .cmd_strobe (cmd_strobe),
        .cmd_err    (cmd_err)
    );

    ping_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .cmd_byte   (cmd_byte),
        .cmd_strobe (cmd_strobe),
        .ping_start (ping_start),
        .run_done   (run_done),
        .first_ping (first_ping),
        .busy       (busy)
    );

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_timer
        echo_timer u_timer (
            .clk        (clk),
            .rst        (rst),
            .ping_start (ping_start),
            .first_ping (first_ping),
            .run_done   (run_done),
            .echo       (echo[ch]),
            .first_sum  (first_sums[ch*SUM_W +: SUM_W]),
            .last_sum   (last_sums[ch*SUM_W +: SUM_W]),
            .hit_count  (hit_counts[ch*HIT_W +: HIT_W])
        );
    end

    result_collector u_col (
        .clk              (clk),
        .rst              (rst),
        .run_done         (run_done),
        .first_sums       (first_sums),
        .last_sums        (last_sums),
        .hit_counts       (hit_counts),
        .result_valid     (result_valid),
        .result_channel   (result_channel),
        .result_hits      (result_hits),
        .result_first_sum (result_first_sum),
        .result_last_sum  (result_last_sum)
    );

endmodule

`default_nettype wire

//--- tb_ranging.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ranging;

    import ranging_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h0d6c2b5f;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int          RUN_LIMIT = 2 * PINGS_PER_RUN * PING_PERIOD;

    logic                    clk;
    logic                    rst;
    logic                    cmd_serial;
    logic [NUM_CHANNELS-1:0] echo;
    logic                    tx_pulse;
    logic                    busy;
    logic                    cmd_err;
    logic                    result_valid;
    logic [CHAN_W-1:0]       result_channel;
    logic [HIT_W-1:0]        result_hits;
    logic [SUM_W-1:0]        result_first_sum;
    logic [SUM_W-1:0]        result_last_sum;

    logic [31:0]             lfsr_state = LFSR_SEED;
    logic [PING_PERIOD-1:0]  win_mask [NUM_CHANNELS];  // Bit d is an echo at offset d.
    logic [NUM_CHANNELS-1:0] edge_echo;                 // Echo on the run_done cycle.
    int                      exp_hits [NUM_CHANNELS];
    int                      exp_first [NUM_CHANNELS];
    int                      exp_last [NUM_CHANNELS];
    int                      errors = 0;
    int                      checks = 0;
    int                      cyc = 0;
    int                      win_d = 0;
    int                      last_pulse_cyc = 0;
    int                      run_pulses = 0;
    int                      pulse_total = 0;
    int                      err_total = 0;
    logic                    busy_prev;
    logic                    timed_out = 1'b0;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ranging_top u_dut (
        .clk              (clk),
        .rst              (rst),
        .cmd_serial       (cmd_serial),
        .echo             (echo),
        .tx_pulse         (tx_pulse),
        .busy             (busy),
        .cmd_err          (cmd_err),
        .result_valid     (result_valid),
        .result_channel   (result_channel),
        .result_hits      (result_hits),
        .result_first_sum (result_first_sum),
        .result_last_sum  (result_last_sum)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // One LFSR step per bit.
    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    task automatic check_eq(input string name, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic note_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("error: timed out waiting for %s", what);
    endtask

    // Random echoes for one window go straight into the expected totals.
    task automatic make_window(input int ch);
        int n;
        int i;
        int off;
        int first_d;
        int last_d;
        win_mask[ch] = '0;
        win_mask[ch][0] = (rand_bits(1) != 0);  // Lands on the tx_pulse cycle.
        edge_echo[ch] = (rand_bits(1) != 0);
        if (rand_bits(1) != 0) begin
            n = rand_bits(2);
            for (i = 0; i < n; i++) begin
                off = rand_bits(OFFSET_W);
                if (off == 0) begin
                    off = 1;
                end
                win_mask[ch][off] = 1'b1;
            end
        end
        first_d = 0;
        last_d = 0;
        for (i = 1; i < PING_PERIOD; i++) begin
            if (win_mask[ch][i]) begin
                if (first_d == 0) begin
                    first_d = i;
                end
                last_d = i;
            end
        end
        if (first_d != 0) begin
            exp_hits[ch] += 1;
            exp_first[ch] += first_d;
            exp_last[ch] += last_d;
        end
    endtask

    task automatic drive_bit(input logic b);
        cmd_serial = b;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    // 8N1 frame with LSB first and one idle bit time after it.
    task automatic send_byte(input logic [7:0] data, input logic stop_level);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_level);
        drive_bit(1'b1);
    endtask

    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        while (busy !== level && n < RUN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            note_timeout(what);
        end
    endtask

    task automatic watch_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_true(!(tx_pulse || busy || cmd_err || result_valid),
                       "output active after reset with an idle serial line");
        end
    endtask

    task automatic check_results(input string name);
        int n;
        int ch;
        n = 0;
        while (!result_valid && n < 4 * NUM_CHANNELS) begin
            @(negedge clk);
            n++;
        end
        if (!result_valid) begin
            note_timeout({name, " result_valid"});
        end else begin
            for (ch = 0; ch < NUM_CHANNELS; ch++) begin
                check_true(result_valid,
                           "result_valid dropped before all channels were drained");
                check_eq($sformatf("%s ch%0d index", name, ch), ch, int'(result_channel));
                check_eq($sformatf("%s ch%0d hits", name, ch), exp_hits[ch],
                         int'(result_hits));
                check_eq($sformatf("%s ch%0d first sum", name, ch), exp_first[ch],
                         int'(result_first_sum));
                check_eq($sformatf("%s ch%0d last sum", name, ch), exp_last[ch],
                         int'(result_last_sum));
                @(negedge clk);
            end
            check_true(!result_valid, "result_valid stayed high past the last channel");
        end
    endtask

    task automatic run_once(input string name, input logic restart);
        int errs_before;
        errs_before = err_total;
        send_byte(CMD_START, 1'b1);
        wait_busy(1'b1, {name, " busy high"});
        if (!timed_out && restart) begin
            send_byte(CMD_START, 1'b1);  // Must be ignored mid-run.
        end
        if (!timed_out) begin
            wait_busy(1'b0, {name, " busy low"});
        end
        if (!timed_out) begin
            check_eq({name, " pulses"}, PINGS_PER_RUN, run_pulses);
            check_eq({name, " cmd_err strobes"}, errs_before, err_total);
            check_results(name);
        end
    endtask

    // Pulse monitor and echo driver. Window offsets count from each tx_pulse.
    initial begin
        int ch;
        echo = '0;
        edge_echo = '0;
        busy_prev = 1'b0;
        for (ch = 0; ch < NUM_CHANNELS; ch++) begin
            win_mask[ch] = '0;
        end
        forever begin
            @(negedge clk);
            cyc++;
            if (rst) begin
                busy_prev = 1'b0;
                echo = '0;
            end else begin
                if (cmd_err) begin
                    err_total++;
                end
                if (!busy_prev && busy) begin
                    check_true(tx_pulse, "busy rose without a tx_pulse");
                end
                if (busy_prev && !busy) begin
                    check_eq("busy fall after last pulse", PING_PERIOD + 1,
                             cyc - last_pulse_cyc);
                end
                if (tx_pulse) begin
                    pulse_total++;
                    check_true(busy, "tx_pulse while busy is low");
                    if (!busy_prev) begin
                        run_pulses = 0;  // First ping clears the totals.
                        for (ch = 0; ch < NUM_CHANNELS; ch++) begin
                            exp_hits[ch] = 0;
                            exp_first[ch] = 0;
                            exp_last[ch] = 0;
                        end
                    end else begin
                        check_eq("ping spacing", PING_PERIOD, cyc - last_pulse_cyc);
                    end
                    run_pulses++;
                    last_pulse_cyc = cyc;
                    win_d = 0;
                    for (ch = 0; ch < NUM_CHANNELS; ch++) begin
                        make_window(ch);
                    end
                end else if (busy) begin
                    win_d++;
                end
                for (ch = 0; ch < NUM_CHANNELS; ch++) begin
                    if (!busy) begin
                        echo[ch] = 1'b0;
                    end else if (win_d < PING_PERIOD) begin
                        echo[ch] = win_mask[ch][win_d];
                    end else begin
                        echo[ch] = edge_echo[ch];  // run_done cycle.
                    end
                end
                busy_prev = busy;
            end
        end
    end

    initial begin
        int i;
        int pulses_before;
        int errs_before;
        logic [7:0] b;
        rst = 1'b1;
        cmd_serial = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        watch_idle(3 * CLKS_PER_BIT);

        run_once("run 1", 1'b0);

        if (!timed_out) begin
            pulses_before = pulse_total;
            errs_before = err_total;
            for (i = 0; i < 3; i++) begin
                b = 8'(rand_bits(8));
                if (b == CMD_START) begin
                    b = b ^ 8'h01;
                end
                send_byte(b, 1'b1);
                check_eq("non-start byte pulses", pulses_before, pulse_total);
                check_true(!busy, "non-start byte started a run");
            end
            check_eq("cmd_err on good bytes", errs_before, err_total);

            // Low stop bit.
            send_byte(CMD_START, 1'b0);
            check_eq("framing error strobes", errs_before + 1, err_total);
            check_eq("pulses after framing error", pulses_before, pulse_total);
            check_true(!busy, "byte with a low stop bit started a run");

            run_once("run 2", 1'b1);
        end

        finish_run();
    end

endmodule

`default_nettype wire

//--- sources.f
ranging_pkg.sv
serial_cmd_rx.sv
ping_sequencer.sv
echo_timer.sv
result_collector.sv
ranging_top.sv
tb_ranging.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ranging -f sources.f -o sim_ranging

./obj_dir/sim_ranging 2>&1 | tee sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
